//--- ising_pkg.sv
// Shared definitions for the Ising spin path
// Spin vector width and spin type
// Host control struct and core result struct
// Widths used by the energy and magnetization datapath

package ising_pkg;

    // Spins per vector, one spin per bit
    localparam int N_SPIN = 16;

    // Signed width of energy and magnetization, covers -16 to +16
    localparam int ENERGY_W = 6;

    // Width of a bit count over one spin vector, 0 to N_SPIN
    localparam int CNT_W = $clog2(N_SPIN + 1);

    // Bit 1 is spin +1, bit 0 is spin -1
    typedef logic [N_SPIN-1:0] spin_t;

    // Host control levels and pulses
    typedef struct packed {
        logic en;
        logic flush;
        logic cmpt_en;
        logic host_readout;
    } anneal_ctrl_t;

    // Per-spin result of the ring core
    typedef struct packed {
        logic signed [ENERGY_W-1:0] energy;
        logic signed [ENERGY_W-1:0] magnet;
    } ising_result_t;

endpackage

//--- ising_ring_core.sv
// Ring Ising core for a uniform ferromagnetic ring
// Per-pop energy and magnetization, registered as a one-cycle strobe
// Iteration counter with sticky finish flag

`timescale 1ns/1ps

module ising_ring_core #(
    parameter int ITER_W = 8
) (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  ising_pkg::anneal_ctrl_t  ctrl_i,
    input  logic [ITER_W-1:0]        n_iter_i,
    input  logic                     spin_pop_valid_i,
    input  ising_pkg::spin_t         spin_i,
    output logic                     spin_pop_ready_o,
    input  logic                     cmpt_busy_i,
    output logic                     result_valid_o,
    output ising_pkg::ising_result_t result_o,
    output logic                     icon_finish_o
);
    import ising_pkg::*;

    logic          pop_fire;
    logic          iter_fire;
    spin_t         spin_rot;
    logic [CNT_W-1:0] up_cnt;
    logic [CNT_W-1:0] dis_cnt;
    ising_result_t result_c;
    ising_result_t result_q;
    logic          result_valid_q;
    logic [ITER_W-1:0] iter_q;
    logic [ITER_W-1:0] iter_next;
    logic          finish_q;

    function automatic logic [CNT_W-1:0] popcount(input spin_t v);
        logic [CNT_W-1:0] c;
        c = '0;
        for (int i = 0; i < N_SPIN; i++) begin
            c = c + CNT_W'(v[i]);
        end
        return c;
    endfunction

    // Ready while running, forced high so readout drains
    assign spin_pop_ready_o = (ctrl_i.en & ~finish_q) | ctrl_i.host_readout;
    assign pop_fire         = spin_pop_valid_i & spin_pop_ready_o;

    // Readout pops after finish do not advance the count
    assign iter_fire = pop_fire & cmpt_busy_i & ~finish_q;
    assign iter_next = iter_q + 1'b1;

    // Right neighbour of each spin, bit N_SPIN-1 wraps to bit 0
    assign spin_rot = {spin_i[0], spin_i[N_SPIN-1:1]};
    assign up_cnt   = popcount(spin_i);
    assign dis_cnt  = popcount(spin_i ^ spin_rot);

    // E = -sum(s_i * s_i+1) = 2 * disagreements - N_SPIN
    assign result_c.energy = ENERGY_W'({dis_cnt, 1'b0}) - ENERGY_W'(N_SPIN);
    // M = up - down = 2 * up - N_SPIN
    assign result_c.magnet = ENERGY_W'({up_cnt, 1'b0}) - ENERGY_W'(N_SPIN);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_valid_q <= 1'b0;
        end else begin
            result_valid_q <= pop_fire;
        end
    end

    // Result payload captured at the pop edge
    always_ff @(posedge clk_i) begin
        if (pop_fire) begin
            result_q <= result_c;
        end
    end

    // Finish rises together with the count reaching the target,
    // so no extra busy pop slips through
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            iter_q   <= '0;
            finish_q <= 1'b0;
        end else if (ctrl_i.flush) begin
            iter_q   <= '0;
            finish_q <= 1'b0;
        end else if (iter_fire) begin
            iter_q <= iter_next;
            if (iter_next == n_iter_i) begin
                finish_q <= 1'b1;
            end
        end
    end

    assign result_valid_o = result_valid_q;
    assign result_o       = result_q;
    assign icon_finish_o  = finish_q;

endmodule

//--- ising_top.sv
// Top level of the Ising spin path
// Spin FIFO maintainer feeding the ring core

`timescale 1ns/1ps

module ising_top #(
    parameter int SPIN_DEPTH = 4,
    parameter int ITER_W = 8,
    localparam int USAGE_W = $clog2(SPIN_DEPTH + 1)
) (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  ising_pkg::anneal_ctrl_t  ctrl_i,
    input  logic [ITER_W-1:0]        n_iter_i,
    input  logic                     spin_push_valid_i,
    input  ising_pkg::spin_t         spin_push_i,
    input  logic                     spin_push_none_i,
    output logic                     spin_push_ready_o,
    output logic                     result_valid_o,
    output ising_pkg::ising_result_t result_o,
    output logic                     icon_finish_o,
    output logic                     cmpt_busy_o,
    output logic [USAGE_W-1:0]       fifo_usage_o
);
    import ising_pkg::*;

    // Maintainer to core
    logic  spin_pop_valid;
    spin_t spin_pop;
    // Core back to maintainer
    logic  spin_pop_ready;
    logic  icon_finish;

    spin_fifo_maintainer #(
        .SPIN_DEPTH(SPIN_DEPTH)
    ) u_maintainer (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .ctrl_i           (ctrl_i),
        .icon_finish_i    (icon_finish),
        .spin_push_valid_i(spin_push_valid_i),
        .spin_push_i      (spin_push_i),
        .spin_push_none_i (spin_push_none_i),
        .spin_push_ready_o(spin_push_ready_o),
        .spin_pop_valid_o (spin_pop_valid),
        .spin_pop_o       (spin_pop),
        .spin_pop_ready_i (spin_pop_ready),
        .cmpt_busy_o      (cmpt_busy_o),
        .fifo_usage_o     (fifo_usage_o)
    );

    ising_ring_core #(
        .ITER_W(ITER_W)
    ) u_core (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .ctrl_i          (ctrl_i),
        .n_iter_i        (n_iter_i),
        .spin_pop_valid_i(spin_pop_valid),
        .spin_i          (spin_pop),
        .spin_pop_ready_o(spin_pop_ready),
        .cmpt_busy_i     (cmpt_busy_o),
        .result_valid_o  (result_valid_o),
        .result_o        (result_o),
        .icon_finish_o   (icon_finish)
    );

    assign icon_finish_o = icon_finish;

endmodule

//--- ising_top_chk.sv
// Protocol assertions for the Ising spin path top level
// Pop never offered from an empty FIFO
// Result strobe exactly one cycle after each pop
// Sticky finish until flush

`timescale 1ns/1ps

module ising_top_chk #(
    parameter int SPIN_DEPTH = 4,
    localparam int USAGE_W = $clog2(SPIN_DEPTH + 1)
) (
    input logic                    clk_i,
    input logic                    arst_n_i,
    input ising_pkg::anneal_ctrl_t ctrl_i,
    input logic                    push_valid_i,
    input logic                    push_ready_i,
    input logic                    pop_valid_i,
    input logic                    pop_ready_i,
    input logic                    result_valid_i,
    input logic                    icon_finish_i,
    input logic [USAGE_W-1:0]      fifo_usage_i
);

    int pop_empty_fails = 0;
    int strobe_fails = 0;
    int finish_fails = 0;
    // Spins held in the FIFO as counted from the handshakes alone
    int held_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            held_q <= 0;
        end else if (ctrl_i.flush) begin
            held_q <= 0;
        end else begin
            held_q <= held_q + int'(push_valid_i && push_ready_i)
                    - int'(pop_valid_i && pop_ready_i);
        end
    end

    // Pop only offered for a pushed spin not yet popped
    a_pop_not_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pop_valid_i |-> (held_q > 0 && int'(fifo_usage_i) == held_q))
    else begin
        pop_empty_fails++;
        $error("pop valid with no pushed spin left in the spin FIFO");
    end

    // Every pop strobes and every strobe had a pop
    a_strobe_after_pop: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        result_valid_i == $past(pop_valid_i && pop_ready_i))
    else begin
        strobe_fails++;
        $error("result strobe not aligned one cycle after a pop");
    end

    a_finish_sticky: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (icon_finish_i && !ctrl_i.flush) |=> icon_finish_i)
    else begin
        finish_fails++;
        $error("finish fell without flush");
    end

endmodule

bind ising_top ising_top_chk #(
    .SPIN_DEPTH(SPIN_DEPTH)
) u_chk (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .ctrl_i        (ctrl_i),
    .push_valid_i  (spin_push_valid_i),
    .push_ready_i  (spin_push_ready_o),
    .pop_valid_i   (spin_pop_valid),
    .pop_ready_i   (spin_pop_ready),
    .result_valid_i(result_valid_o),
    .icon_finish_i (icon_finish_o),
    .fifo_usage_i  (fifo_usage_o)
);

//--- project.f
ising_pkg.sv
spin_fifo.sv
spin_fifo_maintainer.sv
ising_ring_core.sv
ising_top.sv
ising_top_chk.sv
tb_ising_top.sv

//--- run.sh
#!/bin/sh
# Build and run the spin path testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_ising_top -f project.f \
    && ./obj_dir/Vtb_ising_top +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TESTBENCH PASSED" sim.log 2>/dev/null && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }

//--- spin_fifo.sv
// Circular spin FIFO without fall-through
// Flush clears pointers and occupancy
// Push-none stores an all-zero entry instead of the data bus

`timescale 1ns/1ps

module spin_fifo #(
    parameter int DEPTH = 4,
    localparam int USAGE_W = $clog2(DEPTH + 1)
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 flush_i,
    input  logic                 push_i,
    input  logic                 push_none_i,
    input  ising_pkg::spin_t     data_i,
    input  logic                 pop_i,
    output ising_pkg::spin_t     data_o,
    output logic                 full_o,
    output logic                 empty_o,
    output logic [USAGE_W-1:0]   usage_o
);
    import ising_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // Storage, no reset on payload
    spin_t mem_q [DEPTH];

    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [USAGE_W-1:0] count_q;
    logic               push_ok;
    logic               pop_ok;

    // Wrap explicitly so non power-of-two depths work
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full_o  = (count_q == USAGE_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign usage_o = count_q;

    // Overflow and underflow are blocked here as well as upstream
    assign push_ok = push_i & ~full_o;
    assign pop_ok  = pop_i & ~empty_o;

    // Head entry comes straight from registered storage
    assign data_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop_ok) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            // Simultaneous push and pop keeps the count
            case ({push_ok, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Write port
    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            // All spins -1 on a push-none entry
            mem_q[wr_ptr_q] <= push_none_i ? '0 : data_i;
        end
    end

endmodule

//--- spin_fifo_maintainer.sv
// Spin FIFO wrapper with push and pop handshakes
// Compute-busy register and pop gating
// Stop condition is finish while the FIFO is full

`timescale 1ns/1ps

module spin_fifo_maintainer #(
    parameter int SPIN_DEPTH = 4,
    localparam int USAGE_W = $clog2(SPIN_DEPTH + 1)
) (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  ising_pkg::anneal_ctrl_t ctrl_i,
    input  logic                    icon_finish_i,
    input  logic                    spin_push_valid_i,
    input  ising_pkg::spin_t        spin_push_i,
    input  logic                    spin_push_none_i,
    output logic                    spin_push_ready_o,
    output logic                    spin_pop_valid_o,
    output ising_pkg::spin_t        spin_pop_o,
    input  logic                    spin_pop_ready_i,
    output logic                    cmpt_busy_o,
    output logic [USAGE_W-1:0]      fifo_usage_o
);

    logic fifo_full;
    logic fifo_empty;
    logic fifo_push;
    logic fifo_pop;
    logic cmpt_busy_q;
    logic cmpt_stop;
    logic within_cmpt;
    logic busy_set;
    logic busy_clr;

    spin_fifo #(
        .DEPTH(SPIN_DEPTH)
    ) u_spin_fifo (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .flush_i    (ctrl_i.flush),
        .push_i     (fifo_push),
        .push_none_i(spin_push_none_i),
        .data_i     (spin_push_i),
        .pop_i      (fifo_pop),
        .data_o     (spin_pop_o),
        .full_o     (fifo_full),
        .empty_o    (fifo_empty),
        .usage_o    (fifo_usage_o)
    );

    // Core finished and nothing can drain without readout
    assign cmpt_stop   = icon_finish_i & fifo_full;
    assign within_cmpt = cmpt_busy_q & ~cmpt_stop;

    // Push side
    assign spin_push_ready_o = ctrl_i.en & ~fifo_full;
    assign fifo_push         = spin_push_valid_i & spin_push_ready_o;

    // Pop side, host readout bypasses the busy gating
    assign spin_pop_valid_o = ctrl_i.en & ~fifo_empty
                            & ((within_cmpt & ~icon_finish_i) | ctrl_i.host_readout);
    assign fifo_pop         = spin_pop_valid_o & spin_pop_ready_i;

    assign busy_set = ctrl_i.cmpt_en & ctrl_i.en;
    assign busy_clr = cmpt_stop | ctrl_i.flush;

    // Compute-busy register, clear has priority over set
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cmpt_busy_q <= 1'b0;
        end else if (busy_clr) begin
            cmpt_busy_q <= 1'b0;
        end else if (busy_set) begin
            cmpt_busy_q <= 1'b1;
        end
    end

    assign cmpt_busy_o = cmpt_busy_q;

endmodule

//--- tb_ising_top.sv
// Testbench for the Ising spin path top level
// Table of known spins plus seeded random spins with a reference model
// Result monitor against a queue of expected results in push order
// Cycle-counter timeout and closing error summary

`timescale 1ns/1ps

module tb_ising_top;
    import ising_pkg::*;

    localparam int SPIN_DEPTH     = 4;
    localparam int ITER_W         = 8;
    localparam int USAGE_W        = $clog2(SPIN_DEPTH + 1);
    localparam int N_TABLE        = 8;
    localparam int N_RAND         = 8;
    localparam int N_PUSH         = N_TABLE + N_RAND;
    // Busy pops before finish while the rest stays for host readout
    localparam int N_ITER         = N_PUSH - SPIN_DEPTH;
    localparam int TIMEOUT_CYCLES = N_PUSH * 20 + 200;
    localparam int SEED           = 32'hd5b8;

    // One stimulus entry with its expected result
    typedef struct packed {
        spin_t                      spin;
        logic                       none;
        logic signed [ENERGY_W-1:0] energy;
        logic signed [ENERGY_W-1:0] magnet;
    } vec_t;

    logic               clk_i = 1'b0;
    logic               arst_n_i;
    anneal_ctrl_t       ctrl_i;
    logic [ITER_W-1:0]  n_iter_i;
    logic               spin_push_valid_i;
    spin_t              spin_push_i;
    logic               spin_push_none_i;
    logic               spin_push_ready_o;
    logic               result_valid_o;
    ising_result_t      result_o;
    logic               icon_finish_o;
    logic               cmpt_busy_o;
    logic [USAGE_W-1:0] fifo_usage_o;

    vec_t          stim [N_PUSH];
    // Monitor queues this expected result when the push is accepted
    ising_result_t exp_next;
    ising_result_t exp_q [$];
    ising_result_t exp_r;
    int            flow_checks = 0;
    int            flow_errors = 0;
    int            mon_checks = 0;
    int            mon_errors = 0;
    int            result_count = 0;
    int            cycle_count = 0;
    int            chk_fails;
    int            total_errors;

    ising_top #(
        .SPIN_DEPTH(SPIN_DEPTH),
        .ITER_W    (ITER_W)
    ) uut (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .ctrl_i           (ctrl_i),
        .n_iter_i         (n_iter_i),
        .spin_push_valid_i(spin_push_valid_i),
        .spin_push_i      (spin_push_i),
        .spin_push_none_i (spin_push_none_i),
        .spin_push_ready_o(spin_push_ready_o),
        .result_valid_o   (result_valid_o),
        .result_o         (result_o),
        .icon_finish_o    (icon_finish_o),
        .cmpt_busy_o      (cmpt_busy_o),
        .fifo_usage_o     (fifo_usage_o)
    );

    always #5 clk_i = ~clk_i;

    function automatic bit value_ok(input string what, input int got, input int exp);
        assert (got == exp) else begin
            $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
        return got == exp;
    endfunction

    // Ising ring model with E = -sum(s_i * s_i+1) and M = sum(s_i)
    function automatic ising_result_t ref_result(input spin_t s, input logic none);
        spin_t         w;
        int            e;
        int            m;
        int            si;
        int            sj;
        ising_result_t r;
        w = none ? '0 : s;
        e = 0;
        m = 0;
        for (int i = 0; i < N_SPIN; i++) begin
            si = w[0] ? 1 : -1;
            sj = w[1] ? 1 : -1;
            e = e - si * sj;
            m = m + si;
            // Next spin moves to bit 0 and wraps around the ring
            w = {w[0], w[N_SPIN-1:1]};
        end
        r.energy = ENERGY_W'(e);
        r.magnet = ENERGY_W'(m);
        return r;
    endfunction

    function automatic vec_t make_vec(input spin_t spin, input logic none,
                                      input int energy, input int magnet);
        vec_t v;
        v.spin   = spin;
        v.none   = none;
        v.energy = ENERGY_W'(energy);
        v.magnet = ENERGY_W'(magnet);
        return v;
    endfunction

    task automatic build_stimulus();
        ising_result_t r;
        // Hand-worked ring results
        stim[0] = make_vec(16'hFFFF, 1'b0, -16, 16);
        stim[1] = make_vec(16'hAAAA, 1'b0, 16, 0);
        // Data bus ignored on push-none
        stim[2] = make_vec(16'h1234, 1'b1, -16, -16);
        stim[3] = make_vec(16'h00FF, 1'b0, -12, 0);
        stim[4] = make_vec(16'h0001, 1'b0, -12, -14);
        stim[5] = make_vec(16'h5555, 1'b0, 16, 0);
        stim[6] = make_vec(16'h0F0F, 1'b0, -8, 0);
        stim[7] = make_vec(16'h0000, 1'b0, -16, -16);
        for (int i = N_TABLE; i < N_PUSH; i++) begin
            stim[i].spin = N_SPIN'($urandom());
            stim[i].none = (($urandom() % 8) == 0);
            r = ref_result(stim[i].spin, stim[i].none);
            stim[i].energy = r.energy;
            stim[i].magnet = r.magnet;
        end
    endtask

    task automatic check_value(input string what, input int got, input int exp);
        flow_checks++;
        if (!value_ok(what, got, exp)) begin
            flow_errors++;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // Holds valid until an edge with ready high and then drops it
    task automatic push_vec(input vec_t v);
        bit accepted;
        accepted = 1'b0;
        spin_push_valid_i = 1'b1;
        spin_push_i       = v.spin;
        spin_push_none_i  = v.none;
        exp_next.energy   = v.energy;
        exp_next.magnet   = v.magnet;
        while (!accepted) begin
            @(negedge clk_i);
            accepted = spin_push_ready_o;
            @(posedge clk_i);
            #1;
        end
        spin_push_valid_i = 1'b0;
    endtask

    // Push accept and result strobe seen mid-cycle
    always @(negedge clk_i) begin
        if (arst_n_i) begin
            if (spin_push_valid_i && spin_push_ready_o) begin
                exp_q.push_back(exp_next);
            end
            if (result_valid_o) begin
                assert (exp_q.size() != 0) else begin
                    mon_errors++;
                    $display("Result strobe at %0t with no spin outstanding", $time);
                end
                if (exp_q.size() != 0) begin
                    exp_r = exp_q.pop_front();
                    mon_checks += 2;
                    if (!value_ok("result energy", int'(result_o.energy), int'(exp_r.energy))) begin
                        mon_errors++;
                    end
                    if (!value_ok("result magnet", int'(result_o.magnet), int'(exp_r.magnet))) begin
                        mon_errors++;
                    end
                    result_count++;
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(SEED));
        arst_n_i          = 1'b0;
        ctrl_i            = '0;
        n_iter_i          = '0;
        spin_push_valid_i = 1'b0;
        spin_push_i       = '0;
        spin_push_none_i  = 1'b0;
        exp_next          = '0;
        build_stimulus();
        repeat (2) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;

        // Reset state and enable
        @(negedge clk_i);
        check_value("push ready after reset", int'(spin_push_ready_o), 0);
        check_value("result valid after reset", int'(result_valid_o), 0);
        check_value("busy after reset", int'(cmpt_busy_o), 0);
        check_value("finish after reset", int'(icon_finish_o), 0);
        check_value("usage after reset", int'(fifo_usage_o), 0);
        @(posedge clk_i);
        #1;
        ctrl_i.en = 1'b1;
        @(negedge clk_i);
        check_value("push ready after enable", int'(spin_push_ready_o), 1);
        @(posedge clk_i);
        #1;

        // Fill the FIFO with busy clear so nothing may pop
        for (int i = 0; i < SPIN_DEPTH; i++) begin
            push_vec(stim[i]);
        end
        wait_cycles(3);
        @(negedge clk_i);
        check_value("push ready with full FIFO", int'(spin_push_ready_o), 0);
        check_value("usage with full FIFO", int'(fifo_usage_o), SPIN_DEPTH);
        check_value("results while idle", result_count, 0);
        check_value("busy before cmpt_en", int'(cmpt_busy_o), 0);

        // Arm computation and stream the rest
        @(posedge clk_i);
        #1;
        n_iter_i       = ITER_W'(N_ITER);
        ctrl_i.cmpt_en = 1'b1;
        @(posedge clk_i);
        #1;
        ctrl_i.cmpt_en = 1'b0;
        check_value("busy after cmpt_en", int'(cmpt_busy_o), 1);
        for (int i = SPIN_DEPTH; i < N_PUSH; i++) begin
            push_vec(stim[i]);
        end

        // Finish and the full FIFO stop computation
        while (!icon_finish_o) begin
            @(negedge clk_i);
        end
        wait_cycles(4);
        @(negedge clk_i);
        check_value("results at finish", result_count, N_ITER);
        check_value("usage at finish", int'(fifo_usage_o), N_PUSH - N_ITER);
        check_value("busy after stop", int'(cmpt_busy_o), 0);
        check_value("push ready at finish", int'(spin_push_ready_o), 0);

        // Host readout drains the leftovers
        @(posedge clk_i);
        #1;
        ctrl_i.host_readout = 1'b1;
        while (fifo_usage_o != '0) begin
            @(negedge clk_i);
        end
        wait_cycles(3);
        @(negedge clk_i);
        check_value("results after readout", result_count, N_PUSH);
        check_value("finish during readout", int'(icon_finish_o), 1);

        // Re-arm busy and hold one spin so flush has state to clear
        @(posedge clk_i);
        #1;
        ctrl_i.host_readout = 1'b0;
        ctrl_i.cmpt_en      = 1'b1;
        @(posedge clk_i);
        #1;
        ctrl_i.cmpt_en = 1'b0;
        push_vec(stim[0]);
        @(negedge clk_i);
        check_value("busy before flush", int'(cmpt_busy_o), 1);
        check_value("usage before flush", int'(fifo_usage_o), 1);

        // Flush clears finish, busy and usage
        @(posedge clk_i);
        #1;
        ctrl_i.flush = 1'b1;
        @(posedge clk_i);
        #1;
        ctrl_i.flush = 1'b0;
        // Held spin is dropped without a result
        exp_q.delete();
        @(negedge clk_i);
        check_value("finish after flush", int'(icon_finish_o), 0);
        check_value("busy after flush", int'(cmpt_busy_o), 0);
        check_value("usage after flush", int'(fifo_usage_o), 0);
        check_value("push ready after flush", int'(spin_push_ready_o), 1);
        check_value("results after flush", result_count, N_PUSH);

        chk_fails = uut.u_chk.pop_empty_fails + uut.u_chk.strobe_fails
                  + uut.u_chk.finish_fails;
        total_errors = flow_errors + mon_errors + chk_fails;
        $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
                 flow_checks + mon_checks, flow_errors + mon_errors, chk_fails);
        if (total_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
